/* rtl/fpu_pkg.sv */
`default_nettype none

package fpu_pkg;

    // Operation codes, codes 3 to 6 are left unnamed and travel as bubbles
    typedef enum logic [2:0] {
        ADD  = 3'b000,
        SUB  = 3'b001,
        MUL  = 3'b010,
        NONE = 3'b111
    } fp_op_e;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
    } fp_word_t;

    localparam logic [7:0] EXP_BIAS = 8'd127;
    localparam logic [7:0] EXP_INF  = 8'hff;
    localparam int         MANT_W   = 24;   // Includes hidden one

    //------------------------------------------------------------------
    // Pipeline register contents
    //------------------------------------------------------------------
    typedef struct packed {
        fp_op_e              op;
        logic                a_sign;
        logic                b_eff_sign;   // Inverted for SUB
        logic [MANT_W-1:0]   a_mant;
        logic [MANT_W-1:0]   b_mant;
        logic [7:0]          exp_diff;     // A exp minus B exp, raw
        logic [7:0]          big_exp;
        logic                special;
        fp_word_t            special_val;
    } exp_stage_t;

    typedef struct packed {
        fp_op_e              op;
        logic                a_sign;
        logic                b_eff_sign;
        logic [7:0]          big_exp;
        logic [MANT_W-1:0]   a_align;
        logic [MANT_W-1:0]   b_align;
        logic [2*MANT_W-1:0] pp_hi;        // A times upper half of B
        logic [2*MANT_W-1:0] pp_lo;        // A times lower half of B
        logic                special;
        fp_word_t            special_val;
    } align_stage_t;

    typedef struct packed {
        fp_op_e              op;
        logic                sign;
        logic [7:0]          exp;
        logic [2*MANT_W-1:0] mant;         // Bit 47 carry, bit 46 units
        logic                is_zero;
        logic                special;
        fp_word_t            special_val;
    } mant_stage_t;

endpackage

`default_nettype wire

/* rtl/fp_exp_stage.sv */
`default_nettype none

module fp_exp_stage (
    input  wire                     FPUCLK,
    input  wire                     RST,
    input  wire fpu_pkg::fp_word_t  a,
    input  wire fpu_pkg::fp_word_t  b,
    input  wire fpu_pkg::fp_op_e    ctrl,
    output fpu_pkg::exp_stage_t     s1
);

    logic a_inf, b_inf, a_zero, b_zero;
    fpu_pkg::exp_stage_t nxt;

    // All-ones exponent is taken as infinity whatever the fraction
    assign a_inf  = (a.exp == fpu_pkg::EXP_INF);
    assign b_inf  = (b.exp == fpu_pkg::EXP_INF);
    assign a_zero = (a.exp == 8'd0) && (a.frac == 23'd0);
    assign b_zero = (b.exp == 8'd0) && (b.frac == 23'd0);

    always_comb
    begin
        nxt.op          = ctrl;
        nxt.a_sign      = a.sign;
        nxt.b_eff_sign  = b.sign ^ (ctrl == fpu_pkg::SUB);
        nxt.a_mant      = {1'b1, a.frac};
        nxt.b_mant      = {1'b1, b.frac};
        nxt.exp_diff    = a.exp - b.exp;
        nxt.big_exp     = (a.exp >= b.exp) ? a.exp : b.exp;   // Tie goes to A
        nxt.special     = 1'b0;
        nxt.special_val = '0;

        case (ctrl)
            fpu_pkg::ADD, fpu_pkg::SUB:
            begin
                nxt.special = a_inf | b_inf | a_zero | b_zero;
                if (a_inf)
                    nxt.special_val = {a.sign, fpu_pkg::EXP_INF, 23'd0};
                else if (b_inf)
                    nxt.special_val = {nxt.b_eff_sign, fpu_pkg::EXP_INF, 23'd0};
                else if (a_zero)
                    nxt.special_val = {nxt.b_eff_sign, b.exp, b.frac};
                else if (b_zero)
                    nxt.special_val = a;
            end
            fpu_pkg::MUL:
            begin
                // Biased sum needs one bias removed
                nxt.big_exp = a.exp + b.exp - fpu_pkg::EXP_BIAS;
                nxt.special = a_inf | b_inf | a_zero | b_zero;
                if (a_inf || b_inf)
                    nxt.special_val = {a.sign ^ b.sign, fpu_pkg::EXP_INF, 23'd0};
                else
                    nxt.special_val = '0;   // Zero times anything is +0
            end
            default: ;                      // Bubble, nothing special
        endcase
    end

    always_ff @(posedge FPUCLK or negedge RST)
    begin
        if (!RST)
            s1 <= '0;
        else
            s1 <= nxt;
    end

endmodule

`default_nettype wire

/* rtl/fp_align_stage.sv */
`default_nettype none

module fp_align_stage (
    input  wire                       FPUCLK,
    input  wire                       RST,
    input  wire fpu_pkg::exp_stage_t  s1,
    output fpu_pkg::align_stage_t     s2
);

    logic [7:0] shamt;
    logic       b_bigger;
    fpu_pkg::align_stage_t nxt;

    // Sign of the raw difference picks the operand to shift
    assign b_bigger = s1.exp_diff[7];
    assign shamt    = b_bigger ? (8'd0 - s1.exp_diff) : s1.exp_diff;

    always_comb
    begin
        nxt.op          = s1.op;
        nxt.a_sign      = s1.a_sign;
        nxt.b_eff_sign  = s1.b_eff_sign;
        nxt.big_exp     = s1.big_exp;
        nxt.a_align     = s1.a_mant;
        nxt.b_align     = s1.b_mant;
        nxt.pp_hi       = '0;
        nxt.pp_lo       = '0;
        nxt.special     = s1.special;
        nxt.special_val = s1.special_val;

        if (s1.op == fpu_pkg::ADD || s1.op == fpu_pkg::SUB)
        begin
            // Bits shifted past the LSB are dropped
            if (b_bigger)
                nxt.a_align = (shamt >= 8'd24) ? '0 : (s1.a_mant >> shamt);
            else
                nxt.b_align = (shamt >= 8'd24) ? '0 : (s1.b_mant >> shamt);
        end
        else if (s1.op == fpu_pkg::MUL)
        begin
            nxt.pp_hi = 48'(s1.a_mant * s1.b_mant[23:12]);
            nxt.pp_lo = 48'(s1.a_mant * s1.b_mant[11:0]);
        end
    end

    always_ff @(posedge FPUCLK or negedge RST)
    begin
        if (!RST)
            s2 <= '0;
        else
            s2 <= nxt;
    end

endmodule

`default_nettype wire

/* rtl/fp_mant_stage.sv */
`default_nettype none

module fp_mant_stage (
    input  wire                         FPUCLK,
    input  wire                         RST,
    input  wire fpu_pkg::align_stage_t  s2,
    output fpu_pkg::mant_stage_t        s3
);

    logic        eff_add;
    logic        a_ge_b;
    logic [24:0] sum;
    logic [23:0] mag;
    logic [47:0] product;
    fpu_pkg::mant_stage_t nxt;

    //------------------------------------------------------------------
    // Mantissa arithmetic
    //------------------------------------------------------------------
    assign eff_add = (s2.a_sign == s2.b_eff_sign);
    assign a_ge_b  = (s2.a_align >= s2.b_align);
    assign sum     = {1'b0, s2.a_align} + {1'b0, s2.b_align};
    assign mag     = a_ge_b ? (s2.a_align - s2.b_align) : (s2.b_align - s2.a_align);

    // Upper partial product sits 12 places higher
    assign product = {s2.pp_hi[35:0], 12'd0} + s2.pp_lo;

    always_comb
    begin
        nxt.op          = s2.op;
        nxt.sign        = s2.a_sign;
        nxt.exp         = s2.big_exp;
        nxt.mant        = '0;
        nxt.is_zero     = 1'b0;
        nxt.special     = s2.special;
        nxt.special_val = s2.special_val;

        case (s2.op)
            fpu_pkg::ADD, fpu_pkg::SUB:
            begin
                if (eff_add)
                begin
                    nxt.mant = {sum, 23'd0};       // Carry lands in bit 47
                end
                else
                begin
                    nxt.mant    = {1'b0, mag, 23'd0};
                    nxt.sign    = a_ge_b ? s2.a_sign : s2.b_eff_sign;
                    nxt.is_zero = (mag == 24'd0);
                end
            end
            fpu_pkg::MUL:
            begin
                nxt.mant = product;
                nxt.sign = s2.a_sign ^ s2.b_eff_sign;
            end
            default: ;
        endcase
    end

    always_ff @(posedge FPUCLK or negedge RST)
    begin
        if (!RST)
            s3 <= '0;
        else
            s3 <= nxt;
    end

endmodule

`default_nettype wire

/* rtl/fp_norm_stage.sv */
`default_nettype none

module fp_norm_stage (
    input  wire                        FPUCLK,
    input  wire                        RST,
    input  wire fpu_pkg::mant_stage_t  s3,
    output fpu_pkg::fp_word_t          out
);

    logic              is_arith;
    logic              zero_sum;
    logic [4:0]        lz;
    logic [47:0]       norm_mant;
    fpu_pkg::fp_word_t nxt_out;

    // Leading zeros below the carry position, input known nonzero
    function automatic logic [4:0] lead_zeros(input logic [23:0] v);
        logic [4:0] n;
        logic       found;
        int         i;
        n     = 5'd0;
        found = 1'b0;
        for (i = 23; i >= 0; i--)
        begin
            if (!found)
            begin
                if (v[i])
                    found = 1'b1;
                else
                    n = n + 5'd1;
            end
        end
        return n;
    endfunction

    assign is_arith  = (s3.op == fpu_pkg::ADD) || (s3.op == fpu_pkg::SUB) ||
                       (s3.op == fpu_pkg::MUL);
    // Cleared pipeline registers also show up as an empty sum
    assign zero_sum  = s3.is_zero || (s3.mant[47:23] == 25'd0);
    assign lz        = lead_zeros(s3.mant[46:23]);
    assign norm_mant = s3.mant << lz;

    //------------------------------------------------------------------
    // Result selection
    //------------------------------------------------------------------
    always_comb
    begin
        nxt_out = '0;
        if (s3.special)
        begin
            nxt_out = s3.special_val;
        end
        else if (s3.op == fpu_pkg::MUL)
        begin
            if (s3.mant[47])
                nxt_out = {s3.sign, s3.exp + 8'd1, s3.mant[46:24]};
            else
                nxt_out = {s3.sign, s3.exp, s3.mant[45:23]};
        end
        else if (zero_sum)
        begin
            nxt_out = '0;                                   // Always +0
        end
        else if (s3.mant[47])
        begin
            nxt_out = {s3.sign, s3.exp + 8'd1, s3.mant[46:24]};    // Carry out
        end
        else
        begin
            nxt_out = {s3.sign, s3.exp - {3'd0, lz}, norm_mant[45:23]};
        end
    end

    always_ff @(posedge FPUCLK or negedge RST)
    begin
        if (!RST)
            out <= '0;
        else if (is_arith)
            out <= nxt_out;          // Bubbles keep the last result
    end

endmodule

`default_nettype wire

/* rtl/fp_alu.sv */
`default_nettype none

module fp_alu (
    input  wire                     FPUCLK,
    input  wire                     RST,
    input  wire fpu_pkg::fp_word_t  a,
    input  wire fpu_pkg::fp_word_t  b,
    input  wire fpu_pkg::fp_op_e    ctrl,
    output fpu_pkg::fp_word_t       out
);

    fpu_pkg::exp_stage_t   s1;
    fpu_pkg::align_stage_t s2;
    fpu_pkg::mant_stage_t  s3;

    //------------------------------------------------------------------
    // Four-stage chain, one register per stage
    //------------------------------------------------------------------
    fp_exp_stage u_exp (
        .FPUCLK (FPUCLK),
        .RST    (RST),
        .a      (a),
        .b      (b),
        .ctrl   (ctrl),
        .s1     (s1)
    );

    fp_align_stage u_align (
        .FPUCLK (FPUCLK),
        .RST    (RST),
        .s1     (s1),
        .s2     (s2)
    );

    fp_mant_stage u_mant (
        .FPUCLK (FPUCLK),
        .RST    (RST),
        .s2     (s2),
        .s3     (s3)
    );

    fp_norm_stage u_norm (
        .FPUCLK (FPUCLK),
        .RST    (RST),
        .s3     (s3),
        .out    (out)
    );

endmodule

`default_nettype wire

/* bench/fp_alu_chk.sv */
`default_nettype none

module fp_alu_chk (
    input  wire                     FPUCLK,
    input  wire                     RST,
    input  wire fpu_pkg::fp_word_t  a,
    input  wire fpu_pkg::fp_op_e    ctrl,
    input  wire fpu_pkg::fp_word_t  out
);

    logic is_bubble;
    logic add_inf;

    assign is_bubble = (ctrl != fpu_pkg::ADD) && (ctrl != fpu_pkg::SUB) &&
                       (ctrl != fpu_pkg::MUL);
    assign add_inf   = (ctrl == fpu_pkg::ADD) && (a.exp == fpu_pkg::EXP_INF);

    // A bubble leaves out alone when it reaches the last stage
    bubble_holds: assert property (@(posedge FPUCLK) disable iff (!RST)
        $past(is_bubble, 4) |-> (out == $past(out)))
        else $error("out changed when a bubble left the pipeline");

    inf_add: assert property (@(posedge FPUCLK) disable iff (!RST)
        $past(add_inf, 4) |-> (out.exp == fpu_pkg::EXP_INF))   // Inf in, inf out
        else $error("ADD with infinite A gave a finite result");

    reset_clears: assert property (@(posedge FPUCLK) !RST |-> (out == '0))
        else $error("out not zero during reset");

endmodule

`default_nettype wire

/* bench/fp_alu_tb.sv */
`default_nettype none

module fp_alu_tb;

    localparam int NPAT      = 23;
    localparam int MAX_CYCLE = 8 + 4 * NPAT + 20;   // Reset, gaps, drain

    logic              FPUCLK;
    logic              RST;
    fpu_pkg::fp_word_t a;
    fpu_pkg::fp_word_t b;
    fpu_pkg::fp_op_e   ctrl;
    fpu_pkg::fp_word_t out;

    logic [31:0]       pat_mem [0:4*NPAT-1];      // ctrl, a, b, expected
    fpu_pkg::fp_word_t exp_q [$];
    int                due_q [$];
    fpu_pkg::fp_word_t last_out;                   // Model of the held result
    int                cycle = 0;
    int                gap;
    int                i;

    fp_alu DUT (
        .FPUCLK (FPUCLK),
        .RST    (RST),
        .a      (a),
        .b      (b),
        .ctrl   (ctrl),
        .out    (out)
    );

    bind fp_alu fp_alu_chk u_chk (
        .FPUCLK (FPUCLK),
        .RST    (RST),
        .a      (a),
        .ctrl   (ctrl),
        .out    (out)
    );

    initial
    begin
        FPUCLK = 1'b0;
        forever #5 FPUCLK = ~FPUCLK;
    end

    always @(posedge FPUCLK)
    begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLE)
        begin
            $display("timeout: results still outstanding");
            $display("TEST FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    //----------------------------------------------------------------------
    // Compare and drive helpers
    //----------------------------------------------------------------------
    task automatic check_word(input string name, input fpu_pkg::fp_word_t expected,
                              input fpu_pkg::fp_word_t actual);
        if (actual !== expected)
        begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Compare the oldest result once its cycle comes up
    task automatic compare_oldest();
        if (due_q.size() != 0 && due_q[0] == cycle)
        begin
            check_word("out", exp_q[0], out);
            void'(exp_q.pop_front());
            void'(due_q.pop_front());
        end
    endtask

    task automatic issue(input fpu_pkg::fp_op_e op, input fpu_pkg::fp_word_t av,
                         input fpu_pkg::fp_word_t bv, input fpu_pkg::fp_word_t expected);
        @(negedge FPUCLK);
        compare_oldest();
        ctrl     = op;
        a        = av;
        b        = bv;
        last_out = expected;
        exp_q.push_back(expected);
        due_q.push_back(cycle + 4);                // Out settles four edges on
    endtask

    //----------------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------------
    initial
    begin
        void'($urandom(32'h35f4_0e40));
        $readmemh("bench/fp_alu_patterns.hex", pat_mem);
        RST      = 1'b0;
        a        = '0;
        b        = '0;
        ctrl     = fpu_pkg::NONE;
        last_out = '0;
        repeat (8) @(posedge FPUCLK);
        @(negedge FPUCLK);
        RST = 1'b1;
        check_word("out", '0, out);
        repeat (2) issue(fpu_pkg::NONE, '0, '0, last_out);   // Still zero

        for (i = 0; i < NPAT; i++)
        begin
            issue(fpu_pkg::fp_op_e'(pat_mem[4*i][2:0]), pat_mem[4*i+1],
                  pat_mem[4*i+2], pat_mem[4*i+3]);
            gap = $urandom % 3;                    // Zero gives back-to-back
            repeat (gap) issue(fpu_pkg::NONE, a, b, last_out);
        end

        // Drain whatever is still in flight
        while (exp_q.size() != 0)
        begin
            @(negedge FPUCLK);
            compare_oldest();
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* fp_alu.f */
rtl/fpu_pkg.sv
rtl/fp_exp_stage.sv
rtl/fp_align_stage.sv
rtl/fp_mant_stage.sv
rtl/fp_norm_stage.sv
rtl/fp_alu.sv
bench/fp_alu_chk.sv
bench/fp_alu_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build fp_alu_tb with Verilator, run it, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert -j 0 --top-module fp_alu_tb -f fp_alu.f -o fp_alu_sim
	-./obj_dir/fp_alu_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/fp_alu_patterns.hex */
// ctrl a b expected_out, all hex, one operation per line
0 3f800000 40000000 40400000
0 3fc00000 3fe00000 40500000
1 40400000 3f800000 40000000
1 3f800000 3fc00000 bf000000
0 40a00000 bf400000 40880000
1 40000000 40000000 00000000
0 3f800000 33800000 3f800000
2 3fc00000 3fc00000 40100000
2 c0000000 40400000 c0c00000
2 3f800001 3f800001 3f800002
0 7f800000 3f800000 7f800000
0 3f800000 ff800000 ff800000
0 00000000 c0400000 c0400000
1 40000000 ff800000 7f800000
1 ff800000 3f800000 ff800000
2 7f800000 c0000000 ff800000
1 00000000 bfc00000 3fc00000
2 40400000 ff800000 ff800000
3 40000000 40000000 ff800000
4 3f800000 7f800000 ff800000
5 40400000 3f800000 ff800000
6 00000000 00000000 ff800000
2 00000000 c0a00000 00000000
